// File: hw/spi_csr_pkg.sv
package spi_csr_pkg;

    typedef logic [7:0]   byte_t;       // One SPI byte
    typedef logic [11:0]  csr_addr_t;   // Command low nibble plus one address byte
    typedef logic [19:0]  prom_addr_t;  // Program memory word address
    typedef logic [31:0]  prom_word_t;
    typedef logic [127:0] dbg_t;        // Sixteen bytes with byte 0 in the low bits
    typedef logic [15:0]  rate_t;

    // Command byte fields
    localparam int CMD_WE_BIT  = 7;
    localparam int CMD_TGT_MSB = 5;
    localparam int CMD_TGT_LSB = 4;

    localparam logic [1:0] TGT_CSR  = 2'd0;
    localparam logic [1:0] TGT_PROM = 2'd1;

    // Reply bytes, sent back during the following byte
    localparam byte_t RESP_CMD            = 8'hcc;
    localparam byte_t RESP_CSR_ADDR       = 8'had;
    localparam byte_t RESP_PROM_MID       = 8'ha0;
    localparam byte_t RESP_PROM_LOW       = 8'ha1;
    localparam byte_t RESP_PROM_DATA_BASE = 8'hd0;  // Plus byte position in the word

    // CSR byte address map
    localparam csr_addr_t CSR_VOL_BASE    = 12'h000;
    localparam csr_addr_t CSR_CTRL        = 12'h100;
    localparam csr_addr_t CSR_DBGIN_BASE  = 12'h200;
    localparam csr_addr_t CSR_DBGOUT_BASE = 12'h210;
    localparam csr_addr_t CSR_RATE_BASE   = 12'h300;

    localparam int DBG_BYTES  = 16;
    localparam int RATE_BYTES = 2;

endpackage

// File: hw/spi_byte_trx.sv
`timescale 1ns/1ps

module spi_byte_trx (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               sck_i,
    input  logic               ss_n_i,
    input  logic               mosi_i,
    input  spi_csr_pkg::byte_t tx_byte_i,
    input  logic               tx_load_i,
    output logic               miso_o,
    output spi_csr_pkg::byte_t rx_byte_o,
    output logic               rx_valid_o,
    output logic               sel_idle_o
);

    import spi_csr_pkg::*;

    logic [1:0] sck_sync_q;
    logic [1:0] ss_sync_q;
    logic [1:0] mosi_sync_q;
    logic       sck_prev_q;
    logic       sck_rise;
    logic       sck_fall;
    logic [2:0] bit_cnt_q;
    byte_t      rx_shift_q;
    byte_t      tx_shift_q;
    byte_t      tx_pend_q;
    byte_t      tx_next;
    logic       rx_valid_q;

    // All three lines see the same two-flop delay, so MOSI stays aligned with SCK
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sck_sync_q  <= 2'b00;
            ss_sync_q   <= 2'b11;   // Deselected until the pins say otherwise
            mosi_sync_q <= 2'b00;
            sck_prev_q  <= 1'b0;
        end else begin
            sck_sync_q  <= {sck_sync_q[0], sck_i};
            ss_sync_q   <= {ss_sync_q[0], ss_n_i};
            mosi_sync_q <= {mosi_sync_q[0], mosi_i};
            sck_prev_q  <= sck_sync_q[1];
        end
    end

    assign sck_rise = sck_sync_q[1] & ~sck_prev_q;
    assign sck_fall = ~sck_sync_q[1] & sck_prev_q;

    // A load in the same cycle as the byte boundary still makes it out
    assign tx_next = tx_load_i ? tx_byte_i : tx_pend_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i || ss_sync_q[1]) begin
            bit_cnt_q  <= 3'd0;
            rx_shift_q <= '0;
            tx_shift_q <= '0;
            tx_pend_q  <= '0;
            rx_valid_q <= 1'b0;
        end else begin
            rx_valid_q <= 1'b0;
            if (tx_load_i) begin
                tx_pend_q <= tx_byte_i;
            end
            if (sck_rise) begin
                rx_shift_q <= {rx_shift_q[6:0], mosi_sync_q[1]};
                bit_cnt_q  <= bit_cnt_q + 3'd1;
                if (bit_cnt_q == 3'd7) begin
                    rx_valid_q <= 1'b1;
                end
            end
            if (sck_fall) begin
                if (bit_cnt_q == 3'd0) begin
                    tx_shift_q <= tx_next;  // Falling edge after bit 8 starts the next byte
                end else begin
                    tx_shift_q <= {tx_shift_q[6:0], 1'b0};
                end
            end
        end
    end

    assign miso_o     = tx_shift_q[7];
    assign rx_byte_o  = rx_shift_q;     // Holds the full byte until the next rising edge
    assign rx_valid_o = rx_valid_q;
    assign sel_idle_o = ss_sync_q[1];

endmodule

// File: hw/spi_cmd_engine.sv
`timescale 1ns/1ps

module spi_cmd_engine (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  spi_csr_pkg::byte_t      rx_byte_i,
    input  logic                    rx_valid_i,
    input  logic                    sel_idle_i,
    input  spi_csr_pkg::byte_t      csr_rdata_i,
    output spi_csr_pkg::byte_t      tx_byte_o,
    output logic                    tx_load_o,
    output spi_csr_pkg::csr_addr_t  csr_addr_o,
    output spi_csr_pkg::byte_t      csr_wdata_o,
    output logic                    csr_we_o,
    output spi_csr_pkg::prom_addr_t prom_addr_o,
    output spi_csr_pkg::prom_word_t prom_data_o,
    output logic                    prom_we_o
);

    import spi_csr_pkg::*;

    typedef enum logic [2:0] {
        IDLE_CMD,
        CSR_ADDR,
        CSR_DATA,
        CSR_RESPOND,
        PROM_ADDR_MID,
        PROM_ADDR_LOW,
        PROM_DATA,
        PROM_WRITE
    } state_t;

    state_t     state_q;
    logic       we_q;
    csr_addr_t  csr_addr_q;
    prom_addr_t prom_addr_q;
    prom_word_t word_q;
    logic [1:0] offset_q;       // Next byte lane of word_q to fill
    byte_t      tx_byte_q;
    logic       tx_load_q;
    logic [1:0] cmd_tgt;

    assign cmd_tgt = rx_byte_i[CMD_TGT_MSB:CMD_TGT_LSB];

    // Deselect behaves as a reset, so every frame starts from a command byte
    always_ff @(posedge clk) begin
        if (!rst_n_i || sel_idle_i) begin
            state_q     <= IDLE_CMD;
            we_q        <= 1'b0;
            csr_addr_q  <= '0;
            prom_addr_q <= '0;
            word_q      <= '0;
            offset_q    <= 2'd0;
            tx_byte_q   <= '0;
            tx_load_q   <= 1'b0;
        end else begin
            tx_load_q <= 1'b0;
            case (state_q)
                IDLE_CMD: begin
                    if (rx_valid_i) begin
                        we_q               <= rx_byte_i[CMD_WE_BIT];
                        csr_addr_q[11:8]   <= rx_byte_i[3:0];
                        prom_addr_q[19:16] <= rx_byte_i[3:0];
                        tx_byte_q          <= RESP_CMD;
                        tx_load_q          <= 1'b1;
                        if (cmd_tgt == TGT_CSR) begin
                            state_q <= CSR_ADDR;
                        end else if (cmd_tgt == TGT_PROM) begin
                            state_q <= PROM_ADDR_MID;
                        end
                    end
                end
                CSR_ADDR: begin
                    if (rx_valid_i) begin
                        csr_addr_q[7:0] <= rx_byte_i;
                        tx_byte_q       <= RESP_CSR_ADDR;
                        tx_load_q       <= 1'b1;
                        state_q         <= CSR_DATA;
                    end
                end
                CSR_DATA: begin
                    if (rx_valid_i) begin
                        state_q <= CSR_RESPOND;   // Write lands on this edge
                    end
                end
                CSR_RESPOND: begin
                    tx_byte_q  <= csr_rdata_i;   // Read sees the byte just written
                    tx_load_q  <= 1'b1;
                    csr_addr_q <= csr_addr_q + 12'd1;
                    state_q    <= CSR_DATA;
                end
                PROM_ADDR_MID: begin
                    if (rx_valid_i) begin
                        prom_addr_q[15:8] <= rx_byte_i;
                        tx_byte_q         <= RESP_PROM_MID;
                        tx_load_q         <= 1'b1;
                        state_q           <= PROM_ADDR_LOW;
                    end
                end
                PROM_ADDR_LOW: begin
                    if (rx_valid_i) begin
                        prom_addr_q[7:0] <= rx_byte_i;
                        tx_byte_q        <= RESP_PROM_LOW;
                        tx_load_q        <= 1'b1;
                        state_q          <= PROM_DATA;
                    end
                end
                PROM_DATA: begin
                    if (rx_valid_i) begin
                        word_q[{offset_q, 3'b000} +: 8] <= rx_byte_i;
                        tx_byte_q <= RESP_PROM_DATA_BASE + {6'd0, offset_q};
                        tx_load_q <= 1'b1;
                        offset_q  <= offset_q + 2'd1;
                        if (offset_q == 2'd3 && we_q) begin
                            state_q <= PROM_WRITE;
                        end
                    end
                end
                PROM_WRITE: begin
                    prom_addr_q <= prom_addr_q + 20'd1;
                    state_q     <= PROM_DATA;
                end
                default: begin
                    state_q <= IDLE_CMD;
                end
            endcase
        end
    end

    assign tx_byte_o   = tx_byte_q;
    assign tx_load_o   = tx_load_q;
    assign csr_addr_o  = csr_addr_q;
    assign csr_wdata_o = rx_byte_i;
    assign csr_we_o    = (state_q == CSR_DATA) && rx_valid_i && we_q;
    assign prom_addr_o = prom_addr_q;
    assign prom_data_o = word_q;
    assign prom_we_o   = (state_q == PROM_WRITE);  // Exactly one cycle per full word

endmodule

// File: hw/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile #(
    parameter int NUM_CH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  spi_csr_pkg::csr_addr_t addr_i,
    input  spi_csr_pkg::byte_t     wdata_i,
    input  logic                   we_i,
    input  spi_csr_pkg::dbg_t      nkmd_dbgout_i,
    input  spi_csr_pkg::rate_t     rate_i,
    output spi_csr_pkg::byte_t     rdata_o,
    output logic [NUM_CH*32-1:0]   vol_o,
    output logic                   nkmd_rst_o,
    output spi_csr_pkg::dbg_t      nkmd_dbgin_o
);

    import spi_csr_pkg::*;

    localparam int VOL_BYTES = NUM_CH * 4;
    localparam int VOL_IW    = $clog2(VOL_BYTES);
    localparam int DBG_IW    = $clog2(DBG_BYTES);

    byte_t     vol_q [VOL_BYTES];
    byte_t     dbgin_q [DBG_BYTES];
    logic      ctrl_rst_q;
    csr_addr_t vol_off;
    csr_addr_t dbgin_off;
    csr_addr_t dbgout_off;
    csr_addr_t rate_off;
    logic      in_vol;
    logic      in_ctrl;
    logic      in_dbgin;
    logic      in_dbgout;
    logic      in_rate;

    // Offsets wrap below each base, so one unsigned compare checks the range
    assign vol_off    = addr_i - CSR_VOL_BASE;
    assign dbgin_off  = addr_i - CSR_DBGIN_BASE;
    assign dbgout_off = addr_i - CSR_DBGOUT_BASE;
    assign rate_off   = addr_i - CSR_RATE_BASE;

    assign in_vol    = vol_off < csr_addr_t'(VOL_BYTES);
    assign in_ctrl   = addr_i == CSR_CTRL;
    assign in_dbgin  = dbgin_off < csr_addr_t'(DBG_BYTES);
    assign in_dbgout = dbgout_off < csr_addr_t'(DBG_BYTES);
    assign in_rate   = rate_off < csr_addr_t'(RATE_BYTES);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < VOL_BYTES; i++) begin
                vol_q[i] <= '0;
            end
            for (int i = 0; i < DBG_BYTES; i++) begin
                dbgin_q[i] <= '0;
            end
            ctrl_rst_q <= 1'b1;     // Coprocessor held in reset until released over SPI
        end else if (we_i) begin
            if (in_vol) begin
                vol_q[vol_off[VOL_IW-1:0]] <= wdata_i;
            end
            if (in_dbgin) begin
                dbgin_q[dbgin_off[DBG_IW-1:0]] <= wdata_i;
            end
            if (in_ctrl) begin
                ctrl_rst_q <= wdata_i[0];
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        if (in_vol) begin
            rdata_o = vol_q[vol_off[VOL_IW-1:0]];
        end else if (in_ctrl) begin
            rdata_o = {7'd0, ctrl_rst_q};
        end else if (in_dbgin) begin
            rdata_o = dbgin_q[dbgin_off[DBG_IW-1:0]];
        end else if (in_dbgout) begin
            rdata_o = nkmd_dbgout_i[{dbgout_off[DBG_IW-1:0], 3'b000} +: 8];
        end else if (in_rate) begin
            rdata_o = rate_i[{rate_off[0], 3'b000} +: 8];   // Low byte first
        end
    end

    // Byte 4c+i lands in bits 8i of word c
    for (genvar i = 0; i < VOL_BYTES; i++) begin : g_vol
        assign vol_o[8*i +: 8] = vol_q[i];
    end

    for (genvar i = 0; i < DBG_BYTES; i++) begin : g_dbgin
        assign nkmd_dbgin_o[8*i +: 8] = dbgin_q[i];
    end

    assign nkmd_rst_o = ctrl_rst_q;

endmodule

// File: hw/spi_csr_top.sv
`timescale 1ns/1ps

module spi_csr_top #(
    parameter int NUM_CH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    sck_i,
    input  logic                    ss_n_i,
    input  logic                    mosi_i,
    input  spi_csr_pkg::dbg_t       nkmd_dbgout_i,
    input  spi_csr_pkg::rate_t      rate_i,
    output logic                    miso_o,
    output logic [NUM_CH*32-1:0]    vol_o,
    output logic                    nkmd_rst_o,
    output spi_csr_pkg::dbg_t       nkmd_dbgin_o,
    output spi_csr_pkg::prom_addr_t prom_addr_o,
    output spi_csr_pkg::prom_word_t prom_data_o,
    output logic                    prom_we_o
);

    import spi_csr_pkg::*;

    byte_t     rx_byte;
    logic      rx_valid;
    logic      sel_idle;
    byte_t     tx_byte;
    logic      tx_load;
    csr_addr_t csr_addr;
    byte_t     csr_wdata;
    logic      csr_we;
    byte_t     csr_rdata;

    spi_byte_trx u_trx (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .sck_i      (sck_i),
        .ss_n_i     (ss_n_i),
        .mosi_i     (mosi_i),
        .tx_byte_i  (tx_byte),
        .tx_load_i  (tx_load),
        .miso_o     (miso_o),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid),
        .sel_idle_o (sel_idle)
    );

    spi_cmd_engine u_engine (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rx_byte_i   (rx_byte),
        .rx_valid_i  (rx_valid),
        .sel_idle_i  (sel_idle),
        .csr_rdata_i (csr_rdata),
        .tx_byte_o   (tx_byte),
        .tx_load_o   (tx_load),
        .csr_addr_o  (csr_addr),
        .csr_wdata_o (csr_wdata),
        .csr_we_o    (csr_we),
        .prom_addr_o (prom_addr_o),
        .prom_data_o (prom_data_o),
        .prom_we_o   (prom_we_o)
    );

    csr_regfile #(
        .NUM_CH (NUM_CH)
    ) u_regfile (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .addr_i        (csr_addr),
        .wdata_i       (csr_wdata),
        .we_i          (csr_we),
        .nkmd_dbgout_i (nkmd_dbgout_i),
        .rate_i        (rate_i),
        .rdata_o       (csr_rdata),
        .vol_o         (vol_o),
        .nkmd_rst_o    (nkmd_rst_o),
        .nkmd_dbgin_o  (nkmd_dbgin_o)
    );

endmodule

// File: dv/spi_csr_tb.sv
`timescale 1ns/1ps

module spi_csr_tb;

    import spi_csr_pkg::*;

    localparam int NUM_CH   = 8;
    localparam int HALF_SCK = 5;    // Clock cycles per SCK half period, 50 ns
    localparam int TOTAL_BYTES = 4 + 70 + 55 + 27 + 32 + 28;   // Bytes per test, in test order

    logic                clk;
    logic                rst_n;
    logic                sck;
    logic                ss_n;
    logic                mosi;
    dbg_t                dbgout;
    rate_t               rate;
    logic                miso;
    logic [NUM_CH*32-1:0] vol;
    logic                nkmd_rst;
    dbg_t                dbgin;
    prom_addr_t          prom_addr;
    prom_word_t          prom_data;
    logic                prom_we;

    logic [31:0] lcg_state;
    string       cur_test;
    byte_t       prev_reply;
    byte_t       wr_buf [32];
    byte_t       exp_buf [32];
    byte_t       vol_ref [32];
    byte_t       dbgin_ref [16];
    prom_addr_t  pa_q [$];
    prom_word_t  pw_q [$];

    spi_csr_top #(
        .NUM_CH (NUM_CH)
    ) dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .sck_i         (sck),
        .ss_n_i        (ss_n),
        .mosi_i        (mosi),
        .nkmd_dbgout_i (dbgout),
        .rate_i        (rate),
        .miso_o        (miso),
        .vol_o         (vol),
        .nkmd_rst_o    (nkmd_rst),
        .nkmd_dbgin_o  (dbgin),
        .prom_addr_o   (prom_addr),
        .prom_data_o   (prom_data),
        .prom_we_o     (prom_we)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Every write pulse to the program memory is kept for later comparison
    always @(negedge clk) begin
        if (rst_n && prom_we) begin
            pa_q.push_back(prom_addr);
            pw_q.push_back(prom_data);
        end
    end

    initial begin
        #(TOTAL_BYTES * 8 * 100 * 2 + 16 * 10);
        $display("sim failed");
        $fatal(1, "Watchdog expired before the tests finished");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic byte_t rand_byte();
        logic [31:0] v;
        v = lcg_next();
        return v[31:24];    // Upper bits have the longest period
    endfunction

    function automatic logic [255:0] pack_vol();
        logic [255:0] p;
        p = '0;
        for (int i = 0; i < 32; i++) begin
            p[8*i +: 8] = vol_ref[i];
        end
        return p;
    endfunction

    function automatic dbg_t pack_dbgin();
        dbg_t p;
        p = '0;
        for (int i = 0; i < 16; i++) begin
            p[8*i +: 8] = dbgin_ref[i];
        end
        return p;
    endfunction

    task automatic check_eq(input string what, input logic [255:0] expected,
                            input logic [255:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s, %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            $display("sim failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Mode 0 byte, MSB first; the byte seen on MISO answers the previous byte
    task automatic xfer_byte(input byte_t tx, input byte_t next_reply, output byte_t rx);
        rx = '0;
        for (int i = 7; i >= 0; i--) begin
            mosi = tx[i];
            wait_cycles(HALF_SCK);
            sck = 1'b1;
            rx = {rx[6:0], miso};
            wait_cycles(HALF_SCK);
            sck = 1'b0;
        end
        check_eq("reply", 256'(prev_reply), 256'(rx));
        prev_reply = next_reply;
    endtask

    task automatic frame_begin();
        ss_n = 1'b0;
        prev_reply = 8'h00;     // Transmit register is cleared while deselected
        wait_cycles(4);
    endtask

    task automatic frame_end();
        wait_cycles(HALF_SCK);
        ss_n = 1'b1;
        wait_cycles(8);
    endtask

    task automatic csr_frame(input logic we, input csr_addr_t addr, input int n);
        byte_t rx;
        frame_begin();
        xfer_byte({we, 1'b0, TGT_CSR, addr[11:8]}, RESP_CMD, rx);
        xfer_byte(addr[7:0], RESP_CSR_ADDR, rx);
        for (int k = 0; k < n; k++) begin
            xfer_byte(wr_buf[k], exp_buf[k], rx);
        end
        xfer_byte(8'h00, 8'h00, rx);    // Only brings out the reply to the last data byte
        frame_end();
    endtask

    task automatic prom_frame(input logic we, input prom_addr_t addr, input int words);
        byte_t rx;
        frame_begin();
        xfer_byte({we, 1'b0, TGT_PROM, addr[19:16]}, RESP_CMD, rx);
        xfer_byte(addr[15:8], RESP_PROM_MID, rx);
        xfer_byte(addr[7:0], RESP_PROM_LOW, rx);
        for (int k = 0; k < 4 * words; k++) begin
            xfer_byte(wr_buf[k], RESP_PROM_DATA_BASE + byte_t'(k % 4), rx);
        end
        xfer_byte(8'h00, 8'h00, rx);
        frame_end();
    endtask

    task automatic reset_test();
        cur_test = "reset";
        check_eq("reset nkmd_rst", 256'(1'b1), 256'(nkmd_rst));
        check_eq("reset vol", '0, vol);
        check_eq("reset dbgin", '0, 256'(dbgin));
        check_eq("reset prom pulses", '0, 256'(pa_q.size()));
        wr_buf[0] = 8'h00;
        exp_buf[0] = 8'h01;
        csr_frame(1'b0, CSR_CTRL, 1);
    endtask

    task automatic vol_burst_test();
        cur_test = "vol burst";
        for (int i = 0; i < 32; i++) begin
            wr_buf[i] = rand_byte();
            exp_buf[i] = wr_buf[i];
            vol_ref[i] = wr_buf[i];
        end
        csr_frame(1'b1, CSR_VOL_BASE, 32);
        check_eq("vol packing", pack_vol(), vol);
        cur_test = "vol readback";
        for (int i = 0; i < 32; i++) begin
            wr_buf[i] = 8'h00;
            exp_buf[i] = vol_ref[i];
        end
        csr_frame(1'b0, CSR_VOL_BASE, 32);
    endtask

    task automatic status_read_test();
        logic [255:0] vol_before;
        dbg_t         dbgin_before;
        cur_test = "dbgout read";
        for (int i = 0; i < 16; i++) begin
            wr_buf[i] = 8'h00;
            exp_buf[i] = dbgout[8*i +: 8];
        end
        wr_buf[16] = 8'h00;
        exp_buf[16] = 8'h00;    // 220 hex is unmapped
        csr_frame(1'b0, CSR_DBGOUT_BASE, 17);
        cur_test = "rate read";
        exp_buf[0] = rate[7:0];
        exp_buf[1] = rate[15:8];
        exp_buf[2] = 8'h00;
        csr_frame(1'b0, CSR_RATE_BASE, 3);
        vol_before = vol;
        dbgin_before = dbgin;
        cur_test = "dbgout write";
        for (int i = 0; i < 16; i++) begin
            wr_buf[i] = rand_byte();
            exp_buf[i] = dbgout[8*i +: 8];
        end
        csr_frame(1'b1, CSR_DBGOUT_BASE, 16);
        cur_test = "rate write";
        exp_buf[0] = rate[7:0];
        exp_buf[1] = rate[15:8];
        csr_frame(1'b1, CSR_RATE_BASE, 2);
        cur_test = "unmapped write";
        exp_buf[0] = 8'h00;
        exp_buf[1] = 8'h00;
        csr_frame(1'b1, 12'h400, 2);
        check_eq("status writes vol", vol_before, vol);
        check_eq("status writes dbgin", 256'(dbgin_before), 256'(dbgin));
        check_eq("status writes nkmd_rst", 256'(1'b1), 256'(nkmd_rst));
    endtask

    task automatic ctrl_dbgin_test();
        cur_test = "ctrl release";
        wr_buf[0] = 8'h00;
        exp_buf[0] = 8'h00;
        csr_frame(1'b1, CSR_CTRL, 1);
        check_eq("ctrl release nkmd_rst", '0, 256'(nkmd_rst));
        cur_test = "ctrl set";
        wr_buf[0] = 8'h01;
        exp_buf[0] = 8'h01;
        csr_frame(1'b1, CSR_CTRL, 1);
        check_eq("ctrl set nkmd_rst", 256'(1'b1), 256'(nkmd_rst));
        cur_test = "dbgin burst";
        for (int i = 0; i < 16; i++) begin
            wr_buf[i] = rand_byte();
            exp_buf[i] = wr_buf[i];
            dbgin_ref[i] = wr_buf[i];
        end
        csr_frame(1'b1, CSR_DBGIN_BASE, 16);
        check_eq("dbgin packing", 256'(pack_dbgin()), 256'(dbgin));
    endtask

    task automatic prom_write_test();
        logic [31:0] v;
        prom_addr_t  start;
        cur_test = "prom write";
        check_eq("prom pulses before test", '0, 256'(pa_q.size()));
        v = lcg_next();
        start = v[19:0];
        for (int i = 0; i < 12; i++) begin
            wr_buf[i] = rand_byte();
        end
        prom_frame(1'b1, start, 3);
        check_eq("prom pulse count", 256'(3), 256'(pa_q.size()));
        for (int w = 0; w < 3; w++) begin
            check_eq("prom address", 256'(prom_addr_t'(start + prom_addr_t'(w))), 256'(pa_q[w]));
            check_eq("prom word", 256'({wr_buf[4*w+3], wr_buf[4*w+2], wr_buf[4*w+1],
                                        wr_buf[4*w]}), 256'(pw_q[w]));
        end
        pa_q.delete();
        pw_q.delete();
        cur_test = "prom no write";
        prom_frame(1'b0, start, 3);
        check_eq("prom pulses without write bit", '0, 256'(pa_q.size()));
    endtask

    task automatic framing_test();
        byte_t rx;
        cur_test = "unknown target";
        frame_begin();
        xfer_byte(8'h20, RESP_CMD, rx);     // Target 2 is unknown
        xfer_byte({1'b0, 1'b0, TGT_CSR, 4'h1}, RESP_CMD, rx);
        xfer_byte(8'h00, RESP_CSR_ADDR, rx);
        xfer_byte(8'h00, 8'h01, rx);
        xfer_byte(8'h00, 8'h00, rx);
        frame_end();
        cur_test = "cut burst";
        frame_begin();
        xfer_byte({1'b1, 1'b0, TGT_CSR, 4'h2}, RESP_CMD, rx);
        xfer_byte(8'h00, RESP_CSR_ADDR, rx);
        for (int i = 0; i < 2; i++) begin
            dbgin_ref[i] = rand_byte();
            xfer_byte(dbgin_ref[i], dbgin_ref[i], rx);
        end
        frame_end();
        cur_test = "after cut burst";
        for (int i = 0; i < 16; i++) begin
            wr_buf[i] = 8'h00;
            exp_buf[i] = dbgin_ref[i];
        end
        csr_frame(1'b0, CSR_DBGIN_BASE, 16);
        check_eq("dbgin after cut burst", 256'(pack_dbgin()), 256'(dbgin));
    endtask

    initial begin
        logic [31:0] v;
        lcg_state = 32'h4d28_0870;
        rst_n = 1'b0;
        sck = 1'b0;
        ss_n = 1'b1;
        mosi = 1'b0;
        dbgout = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        v = lcg_next();
        rate = v[15:0];
        prev_reply = 8'h00;
        cur_test = "setup";
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        wait_cycles(4);
        reset_test();
        vol_burst_test();
        status_read_test();
        ctrl_dbgin_test();
        prom_write_test();
        framing_test();
        $display("sim passed");
        $finish;
    end

endmodule

// File: project.f
hw/spi_csr_pkg.sv
hw/spi_byte_trx.sv
hw/spi_cmd_engine.sv
hw/csr_regfile.sv
hw/spi_csr_top.sv
dv/spi_csr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench, then judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module spi_csr_tb -f project.f -o spi_csr_sim > sim.log 2>&1 &&
    ./obj_dir/spi_csr_sim >> sim.log 2>&1 ||
    echo "sim failed: build or simulation exited with an error" >> sim.log
grep -q "sim failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || { echo "PASS"; exit 0; }
